/* logic/sram_ctl_pkg.sv */
// address map constants, field positions, enums and packed structs for the sram control block
`default_nettype none

package sram_ctl_pkg;

  // data path and array geometry
  localparam int data_w = 32;
  localparam int row_w = 5;
  // wait-cycle field sits in cfg0 bits 2..0
  localparam int wait_w = 3;

  // bits 15..12 of the address pick the region
  localparam logic [data_w-1:0] addr_mask = 32'h0000_F000;
  localparam logic [data_w-1:0] cfg_region = 32'h0000_E000;
  localparam logic [data_w-1:0] bist_region = 32'h0000_F000;

  // local control space
  localparam logic [data_w-1:0] cfg0_offset = 32'h0000_0000;
  // two-cycle read latency out of reset
  localparam logic [data_w-1:0] cfg0_reset = 32'h0000_0001;

  // low bit of each address field
  localparam int r0_row_lo = 0;
  localparam int r1_row_lo = 6;
  localparam int rd_type_lo = 14;

  // read type carried in address bits 15..14
  typedef enum logic [1:0] {
    rd_r0      = 2'b00,
    rd_r1      = 2'b01,
    rd_pair_lo = 2'b10,
    rd_pair_hi = 2'b11
  } rd_type_e;

  // source of the returned read word
  typedef enum logic [2:0] {
    sel_r0      = 3'd0,
    sel_r1      = 3'd1,
    sel_pair_lo = 3'd2,
    sel_pair_hi = 3'd3,
    sel_cfg0    = 3'd4,
    sel_bist    = 3'd5,
    sel_cfg     = 3'd6
  } rdata_sel_e;

  // one command strobe with its address and data
  typedef struct packed {
    logic              ctl_val;
    logic              ra_val;
    logic              we;
    logic [3:0]        sel;
    logic [data_w-1:0] adr;
    logic [data_w-1:0] dat;
  } cmd_t;

  // controls for the two read ports and the write port
  typedef struct packed {
    logic              r0_enb;
    logic [row_w-1:0]  r0_adr;
    logic              r1_enb;
    logic [row_w-1:0]  r1_adr;
    logic              w0_enb;
    logic [row_w-1:0]  w0_adr;
    logic [data_w-1:0] w0_dat;
  } ra_port_t;

  // read request from decode to the sequencer
  typedef struct packed {
    logic       start;
    rdata_sel_e src;
  } rd_req_t;

  // words coming back from the array
  typedef struct packed {
    logic [data_w-1:0] r0_dat;
    logic [data_w-1:0] r1_dat;
    logic [data_w-1:0] bist_status;
    logic [data_w-1:0] cfg_rdat;
  } ra_status_t;

endpackage

`default_nettype wire

/* logic/cmd_decode.sv */
// command decode into region hits, array port controls, register strobes and read requests
`timescale 1ns/1ns
`default_nettype none

module cmd_decode
  import sram_ctl_pkg::*;
(
  input  cmd_t              cmd,
  input  logic              idle,
  output ra_port_t          ra,
  output logic [data_w-1:0] bist_ctl,
  output logic              cfg_wr,
  output logic [data_w-1:0] cfg_wdat,
  output logic              cfg0_we,
  output rd_req_t           rd_req
);

  logic     bist_hit;
  logic     cfg_hit;
  logic     special;
  logic     ra_rd;
  logic     ra_wr;
  rd_type_e rd_type;

  // region match on the masked address bits
  assign bist_hit = (cmd.adr & addr_mask) == (bist_region & addr_mask);
  assign cfg_hit  = (cmd.adr & addr_mask) == (cfg_region & addr_mask);
  // special regions never touch the read ports
  assign special  = bist_hit | cfg_hit;

  assign ra_rd = cmd.ra_val & ~cmd.we;
  assign ra_wr = cmd.ra_val & cmd.we;

  assign rd_type = rd_type_e'(cmd.adr[rd_type_lo +: $bits(rd_type_e)]);

  // bist control word is only nonzero during the write itself
  assign bist_ctl = (ra_wr & bist_hit) ? cmd.dat : '0;

  // array config write strobe, data goes straight through
  assign cfg_wr   = ra_wr & cfg_hit;
  assign cfg_wdat = cmd.dat;

  // local cfg0 lives at offset zero of the ctl space
  assign cfg0_we = cmd.ctl_val & cmd.we & ((cmd.adr & ~addr_mask) == cfg0_offset);

  // r0 port serves everything but a plain r1 read
  assign ra.r0_enb = ra_rd & ~special & (rd_type != rd_r1);
  assign ra.r0_adr = cmd.adr[r0_row_lo +: row_w];

  // r1 port serves everything but a plain r0 read
  assign ra.r1_enb = ra_rd & ~special & (rd_type != rd_r0);
  // a plain r1 read takes its row from the r0 field
  assign ra.r1_adr = (rd_type == rd_r1) ? cmd.adr[r0_row_lo +: row_w]
                                        : cmd.adr[r1_row_lo +: row_w];

  // sel bit 0 picks the write port
  assign ra.w0_enb = ra_wr & cmd.sel[0];
  assign ra.w0_adr = cmd.adr[r0_row_lo +: row_w];
  assign ra.w0_dat = cmd.dat;

  // reads only start while the sequencer is idle
  assign rd_req.start = idle & ~cmd.we & (cmd.ctl_val | cmd.ra_val);

  // read source select
  always_comb begin
    rd_req.src = sel_cfg0;
    if (cmd.ctl_val) begin
      // ctl space reads
      if (bist_hit) begin
        rd_req.src = sel_bist;
      end else if (cfg_hit) begin
        rd_req.src = sel_cfg;
      end else begin
        rd_req.src = sel_cfg0;
      end
    end else begin
      // array reads follow the read type
      case (rd_type)
        rd_r0:      rd_req.src = sel_r0;
        rd_r1:      rd_req.src = sel_r1;
        rd_pair_lo: rd_req.src = sel_pair_lo;
        rd_pair_hi: rd_req.src = sel_pair_hi;
        default:    rd_req.src = sel_r0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/read_sequencer.sv */
// read sequencer holding cfg0, the busy flag, the latched source and the wait counter
`timescale 1ns/1ns
`default_nettype none

module read_sequencer
  import sram_ctl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cfg0_we,
  input  logic [data_w-1:0] cfg0_wdat,
  input  rd_req_t           rd_req,
  output logic              idle,
  output logic              rd_ack,
  output rdata_sel_e        src,
  output logic [data_w-1:0] cfg0
);

  // cfg0 register
  // bits 31..3 are kept but unused
  // bits 2..0 give wait cycles after the command cycle
  logic [data_w-1:0] cfg0_q;

  // read state
  logic              busy_q;
  logic [wait_w-1:0] wait_q;
  rdata_sel_e        src_q;

  logic              start;
  logic              wait_done;

  // decode raises start only while idle
  assign start = rd_req.start;

  // counter has run out
  assign wait_done = (wait_q == '0);

  // cfg0 takes the write at the sampling edge
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg0_q <= cfg0_reset;
    end else if (cfg0_we) begin
      cfg0_q <= cfg0_wdat;
    end
  end

  // busy from the start edge until the edge after the ack
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
    end else if (busy_q && wait_done) begin
      busy_q <= 1'b0;
    end
  end

  // wait counter
  // loads the wait field on start, then counts down to zero
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q <= '0;
    end else if (start) begin
      wait_q <= cfg0_q[wait_w-1:0];
    end else if (busy_q && !wait_done) begin
      wait_q <= wait_q - 1'b1;
    end
  end

  // source is latched with the start and held through the ack
  always_ff @(posedge clk) begin
    if (rst) begin
      src_q <= sel_cfg0;
    end else if (start) begin
      src_q <= rd_req.src;
    end
  end

  // ack in the one cycle where busy and the count is zero
  // with wait w that is the cycle after edge k+w
  assign rd_ack = busy_q & wait_done;

  assign idle = ~busy_q;
  assign src  = src_q;
  assign cfg0 = cfg0_q;

endmodule

`default_nettype wire

/* logic/read_data_mux.sv */
// read data select across the array ports, cfg0 and the array status words
`timescale 1ns/1ns
`default_nettype none

module read_data_mux
  import sram_ctl_pkg::*;
(
  input  rdata_sel_e        src,
  input  ra_status_t        status,
  input  logic [data_w-1:0] cfg0,
  output logic [data_w-1:0] rd_dat
);

  localparam int half_w = data_w / 2;

  always_comb begin
    case (src)
      sel_r0: begin
        rd_dat = status.r0_dat;
      end
      sel_r1: begin
        rd_dat = status.r1_dat;
      end
      // r1 low half above r0 low half
      sel_pair_lo: begin
        rd_dat = {status.r1_dat[half_w-1:0], status.r0_dat[half_w-1:0]};
      end
      // r1 high half above r0 high half
      sel_pair_hi: begin
        rd_dat = {status.r1_dat[data_w-1:half_w], status.r0_dat[data_w-1:half_w]};
      end
      sel_cfg0: begin
        rd_dat = cfg0;
      end
      sel_bist: begin
        rd_dat = status.bist_status;
      end
      sel_cfg: begin
        rd_dat = status.cfg_rdat;
      end
      // unused select code reads back all ones
      default: begin
        rd_dat = '1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/sram_ctl_top.sv */
// top level joining command decode, read sequencer and read data mux to the command and array ports
`timescale 1ns/1ns
`default_nettype none

module sram_ctl_top
  import sram_ctl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // command strobe and array return words
  input  cmd_t              cmd,
  input  ra_status_t        status,

  // read return
  output logic              rd_ack,
  output logic [data_w-1:0] rd_dat,

  // array controls
  output ra_port_t          ra,
  output logic [data_w-1:0] bist_ctl,
  output logic              cfg_wr,
  output logic [data_w-1:0] cfg_wdat
);

  logic              idle;
  logic              cfg0_we;
  logic [data_w-1:0] cfg0;
  rd_req_t           rd_req;
  rdata_sel_e        src;

  // input side
  // all array strobes are combinational in the command cycle
  cmd_decode u_cmd_decode (
    .cmd      (cmd),
    .idle     (idle),
    .ra       (ra),
    .bist_ctl (bist_ctl),
    .cfg_wr   (cfg_wr),
    .cfg_wdat (cfg_wdat),
    .cfg0_we  (cfg0_we),
    .rd_req   (rd_req)
  );

  // processing part
  // cfg0 write data is the command data word
  read_sequencer u_read_sequencer (
    .clk       (clk),
    .rst       (rst),
    .cfg0_we   (cfg0_we),
    .cfg0_wdat (cmd.dat),
    .rd_req    (rd_req),
    .idle      (idle),
    .rd_ack    (rd_ack),
    .src       (src),
    .cfg0      (cfg0)
  );

  // output side
  read_data_mux u_read_data_mux (
    .src    (src),
    .status (status),
    .cfg0   (cfg0),
    .rd_dat (rd_dat)
  );

endmodule

`default_nettype wire

/* bench/tb_sram_ctl.sv */
// testbench for sram_ctl_top with clock, reset, array model, case file reader, stimulus and checks
`timescale 1ns/1ns
`default_nettype none

module tb_sram_ctl
  import sram_ctl_pkg::*;
();

  // cycles allowed from a read command to its ack
  localparam int ack_limit = 16;
  // cycles watched after an ack for a second, unwanted ack
  localparam int quiet_cycles = 8;
  localparam int case_depth = 256;

  logic              clk;
  logic              rst;
  cmd_t              cmd;
  ra_status_t        status;
  logic              rd_ack;
  logic [data_w-1:0] rd_dat;
  ra_port_t          ra;
  logic [data_w-1:0] bist_ctl;
  logic              cfg_wr;
  logic [data_w-1:0] cfg_wdat;

  // header words, then six words per case
  logic [31:0]       case_mem [0:case_depth-1];
  // array model state
  logic [data_w-1:0] mem [0:31];
  logic [data_w-1:0] r0_q;
  logic [data_w-1:0] r1_q;
  logic [data_w-1:0] bist_word;
  logic [data_w-1:0] cfg_word;

  // wait field the bench expects in cfg0
  int                exp_wait;

  sram_ctl_top uut (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .status   (status),
    .rd_ack   (rd_ack),
    .rd_dat   (rd_dat),
    .ra       (ra),
    .bist_ctl (bist_ctl),
    .cfg_wr   (cfg_wr),
    .cfg_wdat (cfg_wdat)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // array model
  // write port stores at the edge, read ports latch on their enable and hold
  always @(posedge clk) begin
    if (rst) begin
      // fill pattern depends on every row bit
      for (int i = 0; i < 32; i++) begin
        mem[i] <= 32'hA5A5_0000 ^ (32'(i) * 32'h0001_0001);
      end
      r0_q <= '0;
      r1_q <= '0;
    end else begin
      if (ra.w0_enb) begin
        mem[ra.w0_adr] <= ra.w0_dat;
      end
      if (ra.r0_enb) begin
        r0_q <= mem[ra.r0_adr];
      end
      if (ra.r1_enb) begin
        r1_q <= mem[ra.r1_adr];
      end
    end
  end

  always_comb begin
    status.r0_dat      = r0_q;
    status.r1_dat      = r1_q;
    status.bist_status = bist_word;
    status.cfg_rdat    = cfg_word;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // one write command, strobes checked in the command cycle
  task automatic send_write(input logic [1:0] kind, input logic [3:0] sel,
                            input logic [31:0] adr, input logic [31:0] dat,
                            input logic [31:0] exp);
    logic exp_cfg_wr;
    @(negedge clk);
    cmd         = '0;
    cmd.ctl_val = (kind == 2'd0);
    cmd.ra_val  = (kind != 2'd0);
    cmd.we      = 1'b1;
    cmd.sel     = sel;
    cmd.adr     = adr;
    cmd.dat     = dat;
    // config strobe only for an array write in region E
    exp_cfg_wr = (kind == 2'd1) && ((adr & 32'h0000_F000) == 32'h0000_E000);
    #1;
    assert (bist_ctl === exp) else begin
      $display("Mismatch bist_ctl: got %h expected %h", bist_ctl, exp);
      stop_with_failure("bist control word wrong");
    end
    assert (cfg_wr === exp_cfg_wr) else begin
      $display("Mismatch cfg_wr: got %h expected %h", cfg_wr, exp_cfg_wr);
      stop_with_failure("config write strobe wrong");
    end
    if (exp_cfg_wr) begin
      assert (cfg_wdat === dat) else begin
        $display("Mismatch cfg_wdat: got %h expected %h", cfg_wdat, dat);
        stop_with_failure("config write data wrong");
      end
    end
    // ctl write with a zero offset lands in cfg0
    if ((kind == 2'd0) && ((adr & 32'hFFFF_0FFF) == 32'h0)) begin
      exp_wait = int'(dat[2:0]);
    end
    @(negedge clk);
    cmd = '0;
  endtask

  // one read command; kind 2 adds a ctl read one cycle later that must be ignored
  task automatic send_read(input logic [1:0] kind, input logic [31:0] adr,
                           input logic [31:0] dat, input logic [31:0] exp);
    int cycles;
    bit acked;
    @(negedge clk);
    cmd         = '0;
    cmd.ctl_val = (kind == 2'd0);
    cmd.ra_val  = (kind != 2'd0);
    cmd.adr     = adr;
    cycles = 0;
    acked  = 1'b0;
    while (!acked) begin
      @(negedge clk);
      cycles++;
      cmd = '0;
      if ((cycles == 1) && (kind == 2'd2)) begin
        cmd.ctl_val = 1'b1;
        cmd.adr     = dat;
      end
      #1;
      if (rd_ack === 1'b1) begin
        acked = 1'b1;
      end else if (cycles >= ack_limit) begin
        stop_with_failure("read was never acknowledged");
      end
    end
    assert (cycles == exp_wait + 1) else begin
      $display("Mismatch rd_ack latency: got %h expected %h", cycles, exp_wait + 1);
      stop_with_failure("read latency wrong");
    end
    assert (rd_dat === exp) else begin
      $display("Mismatch rd_dat: got %h expected %h", rd_dat, exp);
      stop_with_failure("read data wrong");
    end
    // exactly one ack per accepted read
    repeat (quiet_cycles) begin
      @(negedge clk);
      cmd = '0;
      #1;
      assert (rd_ack === 1'b0) else begin
        stop_with_failure("a second rd_ack followed a completed read");
      end
    end
  endtask

  // run length guard
  initial begin
    #50000;
    stop_with_failure("simulation ran out of time");
  end

  initial begin
    int          n_cases;
    int          base;
    logic [1:0]  kind;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp;
    cmd       = '0;
    rst       = 1'b1;
    // cfg0 comes out of reset with a wait of 1
    exp_wait  = 1;
    $readmemh("bench/sram_ctl_cases.txt", case_mem);
    bist_word = case_mem[0];
    cfg_word  = case_mem[1];
    n_cases   = int'(case_mem[2]);
    if ((n_cases < 1) || (3 + 6 * n_cases > case_depth)) begin
      stop_with_failure("case file has no usable case count");
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int c = 0; c < n_cases; c++) begin
      base = 3 + 6 * c;
      kind = case_mem[base][1:0];
      we   = case_mem[base + 1][0];
      sel  = case_mem[base + 2][3:0];
      adr  = case_mem[base + 3];
      dat  = case_mem[base + 4];
      exp  = case_mem[base + 5];
      if (we) begin
        send_write(kind, sel, adr, dat, exp);
      end else begin
        send_read(kind, adr, dat, exp);
      end
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/sram_ctl_cases.txt */
// header: bist status word, config read word, number of cases
// cases: kind (0 ctl, 1 array, 2 array read plus ignored ctl read) we sel adr dat exp
BEEF0001 C0FFEE02 0000001A
// cfg0 after reset, then wait 4 and read back
0 0 0 00000000 00000000 00000001
0 1 1 00000000 00000004 00000000
0 0 0 00000000 00000000 00000004
// fill four rows through w0
1 1 1 00000003 11223344 00000000
1 1 1 00000007 55667788 00000000
1 1 1 0000000A A1B2C3D4 00000000
1 1 1 00000015 9E8D7C6B 00000000
// r0 and r1 reads
1 0 0 00000003 00000000 11223344
1 0 0 00004007 00000000 55667788
// sel bit 0 clear leaves row 3 alone
1 1 E 00000003 DEADBEEF 00000000
1 0 0 00000003 00000000 11223344
1 0 0 00004003 00000000 11223344
// wait 0 from here
0 1 1 00000000 00000000 00000000
// pair reads, r0 row in bits 4..0, r1 row in bits 10..6
1 0 0 0000854A 00000000 7C6BC3D4
1 0 0 0000C54A 00000000 9E8DA1B2
1 0 0 000081C3 00000000 77883344
1 0 0 0000C1C3 00000000 55661122
// bist region write and status read
1 1 0 0000F000 12345678 12345678
0 0 0 0000F000 00000000 BEEF0001
// config region write and read
1 1 0 0000E004 CAFEF00D 00000000
0 0 0 0000E000 00000000 C0FFEE02
// second read while pending, wait 0 and wait 3
2 0 0 00000015 00000000 9E8D7C6B
0 1 1 00000000 00000003 00000000
2 0 0 0000000A 00000000 A1B2C3D4
0 0 0 00000000 00000000 00000003
1 0 0 00000007 00000000 55667788

/* tb.f */
logic/sram_ctl_pkg.sv
logic/cmd_decode.sv
logic/read_sequencer.sv
logic/read_data_mux.sv
logic/sram_ctl_top.sv
bench/tb_sram_ctl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sram control testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_sram_ctl \
  --Mdir "$build_dir" -o sim_tb \
  -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

# the log decides the result
if grep -q "Simulation finished: FAIL" "$log_file"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
